/* rtl/scratch_pkg.sv */
package scratch_pkg;

   // ram geometry
   localparam int MEM_AW = 8;
   localparam int DATA_W = 32;

   // address bit that selects the register space
   localparam int REG_SPACE_BIT = 10;

   typedef logic [DATA_W-1:0]   word_t;
   typedef logic [DATA_W/8-1:0] strb_t;
   typedef logic [11:0]         axil_addr_t;
   typedef logic [MEM_AW-1:0]   mem_addr_t;
   // word count, 0 to 256
   typedef logic [MEM_AW:0]     len_t;
   // register index, byte address bits 5:2
   typedef logic [3:0]          reg_ofs_t;
   typedef logic [1:0]          resp_t;

   // axi responses
   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;

   // register map, base 0x400
   localparam reg_ofs_t REG_CTRL   = 4'd0;
   localparam reg_ofs_t REG_BASE   = 4'd1;
   localparam reg_ofs_t REG_LEN    = 4'd2;
   localparam reg_ofs_t REG_FILL   = 4'd3;
   localparam reg_ofs_t REG_STATUS = 4'd4;
   localparam reg_ofs_t REG_RESULT = 4'd5;

   // ctrl bits
   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_MODE_BIT  = 1;

   // status bits
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_DONE_BIT = 1;

endpackage

/* rtl/scratch_tdpram.sv */
`timescale 1ns/10ps

module scratch_tdpram #(
   parameter int AW = 8,
   parameter int DW = 32
) (
   input  logic            clk_a,
   // port a
   input  logic [AW-1:0]   addr_a,
   input  logic [DW/8-1:0] we_a,
   input  logic [DW-1:0]   din_a,
   input  logic            en_a,
   output logic [DW-1:0]   dout_a,
   // port b
   input  logic [AW-1:0]   addr_b,
   input  logic [DW/8-1:0] we_b,
   input  logic [DW-1:0]   din_b,
   input  logic            en_b,
   output logic [DW-1:0]   dout_b
);

   // storage shared by both ports
   logic [DW-1:0] mem [0:(1<<AW)-1];

   // start from all zero in simulation
   initial begin
      for (int k = 0; k < (1 << AW); k++) begin
         mem[k] = '0;
      end
   end

   // byte-wise writes, port a then port b
   // same-word collisions have no defined order
   always @(posedge clk_a) begin
      if (en_a) begin
         for (int i = 0; i < DW/8; i++) begin
            if (we_a[i]) begin
               mem[addr_a][i*8 +: 8] <= din_a[i*8 +: 8];
            end
         end
      end
      if (en_b) begin
         for (int j = 0; j < DW/8; j++) begin
            if (we_b[j]) begin
               mem[addr_b][j*8 +: 8] <= din_b[j*8 +: 8];
            end
         end
      end
   end

   // write-first output registers
   always_ff @(posedge clk_a) begin
      if (en_a) begin
         dout_a <= (|we_a) ? din_a : mem[addr_a];
      end
      if (en_b) begin
         dout_b <= (|we_b) ? din_b : mem[addr_b];
      end
   end

endmodule

/* rtl/scratch_axil_slave.sv */
`timescale 1ns/10ps

module scratch_axil_slave
   import scratch_pkg::*;
(
   input  logic       clk_a,
   input  logic       rst_n,
   // write address and data
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  word_t      wdata,
   input  strb_t      wstrb,
   input  logic       wvalid,
   output logic       wready,
   // write response
   output resp_t      bresp,
   output logic       bvalid,
   input  logic       bready,
   // read address and data
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output word_t      rdata,
   output resp_t      rresp,
   output logic       rvalid,
   input  logic       rready,
   // ram port a
   output mem_addr_t  addr_a,
   output logic       en_a,
   output strb_t      we_a,
   output word_t      din_a,
   input  word_t      dout_a,
   // register block strobes
   output logic       reg_wr,
   output logic       reg_rd,
   output reg_ofs_t   reg_ofs,
   output word_t      reg_wdata,
   input  word_t      reg_rdata,
   input  logic       reg_err
);

   // target decode, high means register space
   logic wr_reg;
   logic rd_reg;
   // handshakes
   logic ar_hs;
   logic wr_go;
   logic wr_block;
   // read pipeline
   logic rd_p1;
   logic rd_p2;
   logic rd_is_reg;

   assign wr_reg = awaddr[REG_SPACE_BIT];
   assign rd_reg = araddr[REG_SPACE_BIT];

   // one read in flight at a time
   assign arready = ~(rd_p1 | rd_p2 | rvalid);
   assign ar_hs   = arvalid & arready;

   // a write yields to a read that needs the same target this cycle,
   // and to a register read whose reg_err is still due
   assign wr_block = (ar_hs & (rd_reg == wr_reg)) | (rd_p1 & rd_is_reg & wr_reg);

   // aw and w taken together, only with no response pending
   assign wr_go   = awvalid & wvalid & ~bvalid & ~wr_block;
   assign awready = wr_go;
   assign wready  = wr_go;

   // ram port a, read has the port when both want it
   assign en_a   = (ar_hs & ~rd_reg) | (wr_go & ~wr_reg);
   assign we_a   = (wr_go & ~wr_reg) ? wstrb : '0;
   assign addr_a = (ar_hs & ~rd_reg) ? araddr[MEM_AW+1:2] : awaddr[MEM_AW+1:2];
   assign din_a  = wdata;

   // register strobes, single cycle
   assign reg_rd    = ar_hs & rd_reg;
   assign reg_wr    = wr_go & wr_reg;
   assign reg_ofs   = reg_rd ? araddr[$bits(reg_ofs_t)+1:2] : awaddr[$bits(reg_ofs_t)+1:2];
   assign reg_wdata = wdata;

   // write response
   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
         bresp  <= RESP_OKAY;
      end else begin
         if (wr_go) begin
            bvalid <= 1'b1;
            // reg_err answers a write in the same cycle
            bresp  <= (wr_reg & reg_err) ? RESP_SLVERR : RESP_OKAY;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // read pending flags and response
   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         rd_p1     <= 1'b0;
         rd_p2     <= 1'b0;
         rd_is_reg <= 1'b0;
         rvalid    <= 1'b0;
         rresp     <= RESP_OKAY;
      end else begin
         rd_p1 <= ar_hs;
         rd_p2 <= rd_p1;
         if (ar_hs) begin
            rd_is_reg <= rd_reg;
         end
         // ram and register data both valid one edge after the strobe
         if (rd_p1) begin
            rresp <= (rd_is_reg & reg_err) ? RESP_SLVERR : RESP_OKAY;
         end
         if (rd_p2) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // read data, zero on a register error
   always_ff @(posedge clk_a) begin
      if (rd_p1) begin
         if (rd_is_reg) begin
            rdata <= reg_err ? '0 : reg_rdata;
         end else begin
            rdata <= dout_a;
         end
      end
   end

endmodule

/* rtl/scratch_regs.sv */
`timescale 1ns/10ps

module scratch_regs
   import scratch_pkg::*;
(
   input  logic      clk_a,
   input  logic      rst_n,
   // strobes from the axi slave
   input  logic      reg_wr,
   input  logic      reg_rd,
   input  reg_ofs_t  reg_ofs,
   input  word_t     reg_wdata,
   output word_t     reg_rdata,
   output logic      reg_err,
   // engine side
   input  logic      busy,
   input  logic      done,
   input  word_t     result,
   output logic      start,
   output logic      mode,
   output mem_addr_t base,
   output len_t      len,
   output word_t     fill_value
);

   logic      bad_ofs;
   logic      ctrl_wr;
   logic      mode_q;
   logic      start_q;
   logic      done_q;
   logic      rd_err_q;
   mem_addr_t base_q;
   len_t      len_q;
   word_t     fill_q;
   word_t     result_q;
   word_t     rd_mux;
   word_t     rd_data_q;

   // index past RESULT is unmapped
   assign bad_ofs = (reg_ofs > REG_RESULT);
   // ctrl writes ignored while a job runs
   assign ctrl_wr = reg_wr & (reg_ofs == REG_CTRL) & ~busy;

   // write error now, read error one edge after reg_rd
   assign reg_err = reg_wr ? bad_ofs : rd_err_q;

   always_comb begin
      rd_mux = '0;
      case (reg_ofs)
         REG_CTRL:   rd_mux[CTRL_MODE_BIT] = mode_q;
         REG_BASE:   rd_mux = word_t'(base_q);
         REG_LEN:    rd_mux = word_t'(len_q);
         REG_FILL:   rd_mux = fill_q;
         REG_STATUS: begin
            rd_mux[STAT_BUSY_BIT] = busy;
            rd_mux[STAT_DONE_BIT] = done_q;
         end
         REG_RESULT: rd_mux = result_q;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         base_q   <= '0;
         len_q    <= '0;
         fill_q   <= '0;
         mode_q   <= 1'b0;
         start_q  <= 1'b0;
         done_q   <= 1'b0;
         result_q <= '0;
         rd_err_q <= 1'b0;
      end else begin
         // start pulse, one cycle
         start_q <= ctrl_wr & reg_wdata[CTRL_START_BIT];
         if (ctrl_wr) begin
            mode_q <= reg_wdata[CTRL_MODE_BIT];
         end
         if (reg_wr) begin
            case (reg_ofs)
               REG_BASE: base_q <= reg_wdata[MEM_AW-1:0];
               REG_LEN:  len_q  <= reg_wdata[$bits(len_t)-1:0];
               REG_FILL: fill_q <= reg_wdata;
               default:  fill_q <= fill_q;
            endcase
         end
         // sticky done, cleared by the next start
         if (start_q) begin
            done_q <= 1'b0;
         end else if (done) begin
            done_q <= 1'b1;
         end
         if (done) begin
            result_q <= result;
         end
         if (reg_rd) begin
            rd_err_q <= bad_ofs;
         end
      end
   end

   // registered read, same latency as the ram
   always_ff @(posedge clk_a) begin
      if (reg_rd) begin
         rd_data_q <= rd_mux;
      end
   end

   assign reg_rdata  = rd_data_q;
   assign start      = start_q;
   assign mode       = mode_q;
   assign base       = base_q;
   assign len        = len_q;
   assign fill_value = fill_q;

endmodule

/* rtl/scratch_block_engine.sv */
`timescale 1ns/10ps

module scratch_block_engine
   import scratch_pkg::*;
(
   input  logic      clk_a,
   input  logic      rst_n,
   // job setup from the register block
   input  logic      start,
   input  logic      mode,
   input  mem_addr_t base,
   input  len_t      len,
   input  word_t     fill_value,
   // ram port b
   output mem_addr_t addr_b,
   output logic      en_b,
   output strb_t     we_b,
   output word_t     din_b,
   input  word_t     dout_b,
   // status
   output logic      busy,
   output logic      done,
   output word_t     result
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_DRAIN
   } eng_state_t;

   eng_state_t state;
   mem_addr_t  addr_q;
   // words still to issue
   len_t       cnt_q;
   // offset from base, feeds the fill pattern
   len_t       idx_q;
   logic       mode_q;
   // read data valid on dout_b
   logic       rd_v;
   logic       done_q;
   word_t      acc_q;

   assign busy   = (state != ST_IDLE);
   assign en_b   = (state == ST_RUN);
   // fill writes whole words
   assign we_b   = (state == ST_RUN && mode_q) ? '1 : '0;
   assign addr_b = addr_q;
   assign din_b  = fill_value + word_t'(idx_q);
   assign done   = done_q;
   assign result = acc_q;

   always_ff @(posedge clk_a) begin
      if (!rst_n) begin
         state  <= ST_IDLE;
         addr_q <= '0;
         cnt_q  <= '0;
         idx_q  <= '0;
         mode_q <= 1'b0;
         rd_v   <= 1'b0;
         done_q <= 1'b0;
         acc_q  <= '0;
      end else begin
         done_q <= 1'b0;
         // read data arrives one cycle behind its read
         rd_v   <= en_b & ~mode_q;
         if (rd_v) begin
            acc_q <= acc_q + dout_b;
         end
         case (state)
            ST_IDLE: begin
               if (start) begin
                  addr_q <= base;
                  cnt_q  <= len;
                  idx_q  <= '0;
                  mode_q <= mode;
                  // sum starts from zero, fill keeps the last sum
                  if (!mode) begin
                     acc_q <= '0;
                  end
                  state <= (len == '0) ? ST_DRAIN : ST_RUN;
               end
            end
            ST_RUN: begin
               // address wraps modulo the ram size
               addr_q <= addr_q + 1'b1;
               cnt_q  <= cnt_q - 1'b1;
               idx_q  <= idx_q + 1'b1;
               if (cnt_q == len_t'(1)) begin
                  if (mode_q) begin
                     state  <= ST_IDLE;
                     done_q <= 1'b1;
                  end else begin
                     // last word still in flight
                     state <= ST_DRAIN;
                  end
               end
            end
            ST_DRAIN: begin
               state  <= ST_IDLE;
               done_q <= 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* rtl/csum_scratchpad_top.sv */
`timescale 1ns/10ps

module csum_scratchpad_top
   import scratch_pkg::*;
(
   input  logic       clk_a,
   input  logic       rst_n,
   // axi4-lite write
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  word_t      wdata,
   input  strb_t      wstrb,
   input  logic       wvalid,
   output logic       wready,
   output resp_t      bresp,
   output logic       bvalid,
   input  logic       bready,
   // axi4-lite read
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output word_t      rdata,
   output resp_t      rresp,
   output logic       rvalid,
   input  logic       rready
);

   // ram port a, host side
   mem_addr_t addr_a;
   logic      en_a;
   strb_t     we_a;
   word_t     din_a;
   word_t     dout_a;
   // ram port b, engine side
   mem_addr_t addr_b;
   logic      en_b;
   strb_t     we_b;
   word_t     din_b;
   word_t     dout_b;
   // register strobes
   logic      reg_wr;
   logic      reg_rd;
   reg_ofs_t  reg_ofs;
   word_t     reg_wdata;
   word_t     reg_rdata;
   logic      reg_err;
   // job control
   logic      start;
   logic      mode;
   mem_addr_t base;
   len_t      len;
   word_t     fill_value;
   logic      busy;
   logic      done;
   word_t     result;

   scratch_axil_slave axil_i (
      .clk_a     (clk_a),
      .rst_n     (rst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .addr_a    (addr_a),
      .en_a      (en_a),
      .we_a      (we_a),
      .din_a     (din_a),
      .dout_a    (dout_a),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_ofs   (reg_ofs),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .reg_err   (reg_err)
   );

   // control and status for the engine
   scratch_regs regs_i (
      .clk_a      (clk_a),
      .rst_n      (rst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_ofs    (reg_ofs),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_err    (reg_err),
      .busy       (busy),
      .done       (done),
      .result     (result),
      .start      (start),
      .mode       (mode),
      .base       (base),
      .len        (len),
      .fill_value (fill_value)
   );

   scratch_block_engine engine_i (
      .clk_a      (clk_a),
      .rst_n      (rst_n),
      .start      (start),
      .mode       (mode),
      .base       (base),
      .len        (len),
      .fill_value (fill_value),
      .addr_b     (addr_b),
      .en_b       (en_b),
      .we_b       (we_b),
      .din_b      (din_b),
      .dout_b     (dout_b),
      .busy       (busy),
      .done       (done),
      .result     (result)
   );

   // both ports on clk_a
   scratch_tdpram #(
      .AW (MEM_AW),
      .DW (DATA_W)
   ) ram_i (
      .clk_a  (clk_a),
      .addr_a (addr_a),
      .we_a   (we_a),
      .din_a  (din_a),
      .en_a   (en_a),
      .dout_a (dout_a),
      .addr_b (addr_b),
      .we_b   (we_b),
      .din_b  (din_b),
      .en_b   (en_b),
      .dout_b (dout_b)
   );

endmodule

/* tb/scratch_axil_bfm.svh */
`ifndef SCRATCH_AXIL_BFM_SVH
`define SCRATCH_AXIL_BFM_SVH

// lcg step, numerical recipes constants
function automatic word_t lcg_step(inout word_t state);
   state = state * 32'd1664525 + 32'd1013904223;
   return state;
endfunction

// aw and w together, bready held low for stall cycles once bvalid is up
task automatic write_txn(input axil_addr_t addr, input word_t data, input strb_t strb,
                         input int stall, output resp_t resp, output logic held);
   @(posedge clk_a);
   #1;
   awaddr  = addr;
   awvalid = 1'b1;
   wdata   = data;
   wstrb   = strb;
   wvalid  = 1'b1;
   // ready seen at negedge means handshake on the next rising edge
   @(negedge clk_a);
   while (!(awready && wready)) begin
      @(negedge clk_a);
   end
   @(posedge clk_a);
   #1;
   awvalid = 1'b0;
   wvalid  = 1'b0;
   @(negedge clk_a);
   while (!bvalid) begin
      @(negedge clk_a);
   end
   resp = bresp;
   held = 1'b1;
   // response must not move while bready is low
   repeat (stall) begin
      @(negedge clk_a);
      if (!bvalid || bresp !== resp) begin
         held = 1'b0;
      end
   end
   @(posedge clk_a);
   #1;
   bready = 1'b1;
   @(posedge clk_a);
   #1;
   bready = 1'b0;
endtask

// single read, rready held low for stall cycles once rvalid is up
task automatic read_txn(input axil_addr_t addr, input int stall, output word_t data,
                        output resp_t resp, output logic held);
   @(posedge clk_a);
   #1;
   araddr  = addr;
   arvalid = 1'b1;
   @(negedge clk_a);
   while (!arready) begin
      @(negedge clk_a);
   end
   @(posedge clk_a);
   #1;
   arvalid = 1'b0;
   @(negedge clk_a);
   while (!rvalid) begin
      @(negedge clk_a);
   end
   data = rdata;
   resp = rresp;
   held = 1'b1;
   // data, resp stable and no new address accepted
   repeat (stall) begin
      @(negedge clk_a);
      if (!rvalid || rdata !== data || rresp !== resp || arready) begin
         held = 1'b0;
      end
   end
   @(posedge clk_a);
   #1;
   rready = 1'b1;
   @(posedge clk_a);
   #1;
   rready = 1'b0;
endtask

`endif

/* tb/tb_csum_scratchpad.sv */
`timescale 1ns/10ps

module tb_csum_scratchpad
   import scratch_pkg::*;
();

   // watchdog budget of axi ops times cycles per op plus engine time and half again
   localparam int AXI_OPS         = 220;
   localparam int OP_CYCLES       = 8;
   localparam int ENGINE_CYCLES   = 240;
   localparam int WATCHDOG_CYCLES = (AXI_OPS * OP_CYCLES + ENGINE_CYCLES) * 3 / 2;

   logic       clk_a;
   logic       rst_n;
   axil_addr_t awaddr;
   logic       awvalid;
   logic       awready;
   word_t      wdata;
   strb_t      wstrb;
   logic       wvalid;
   logic       wready;
   resp_t      bresp;
   logic       bvalid;
   logic       bready;
   axil_addr_t araddr;
   logic       arvalid;
   logic       arready;
   word_t      rdata;
   resp_t      rresp;
   logic       rvalid;
   logic       rready;

   // predicted ram contents starting from the zeroed ram
   word_t shadow [0:255];
   word_t rng_state;
   strb_t strb_pat [0:7];

   `include "scratch_axil_bfm.svh"

   csum_scratchpad_top dut_i (
      .clk_a   (clk_a),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   // 40 ns period
   always #20 clk_a = ~clk_a;

   task automatic check_value(input string name, input word_t exp, input word_t act);
      assert (act === exp) else begin
         $display("error: %s expected 0x%08h, got 0x%08h", name, exp, act);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("%s", what);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   endtask

   function automatic axil_addr_t mem_byte_addr(input int idx);
      return axil_addr_t'((idx % 256) * 4);
   endfunction

   function automatic axil_addr_t reg_byte_addr(input reg_ofs_t ofs);
      return 12'h400 | axil_addr_t'({ofs, 2'b00});
   endfunction

   // enabled bytes take the new data and the others keep the old
   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                         input strb_t strb);
      word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic expect_write(input axil_addr_t addr, input word_t data, input strb_t strb,
                               input resp_t exp_resp);
      resp_t resp;
      logic  held;
      write_txn(addr, data, strb, 0, resp, held);
      check_value("bresp", word_t'(exp_resp), word_t'(resp));
   endtask

   task automatic expect_read(input axil_addr_t addr, input word_t exp_data,
                              input resp_t exp_resp);
      word_t data;
      resp_t resp;
      logic  held;
      read_txn(addr, 0, data, resp, held);
      check_value("rresp", word_t'(exp_resp), word_t'(resp));
      check_value("rdata", exp_data, data);
   endtask

   // poll STATUS until the sticky done bit shows
   task automatic wait_job_done();
      word_t st;
      resp_t resp;
      logic  held;
      st = '0;
      while (!st[STAT_DONE_BIT]) begin
         read_txn(reg_byte_addr(REG_STATUS), 0, st, resp, held);
         check_value("rresp", word_t'(RESP_OKAY), word_t'(resp));
      end
      check_value("status busy", 32'd0, word_t'(st[STAT_BUSY_BIT]));
   endtask

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_a);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1);
   end

   initial begin
      word_t data;
      word_t rnd;
      word_t fill_val;
      word_t sum;
      resp_t resp;
      logic  held;
      int    idx;
      int    idx_list [0:31];
      clk_a     = 1'b0;
      rst_n     = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      rng_state = 32'hf4b3ce3b;
      strb_pat  = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha};
      for (int i = 0; i < 256; i++) begin
         shadow[i] = '0;
      end
      repeat (4) @(posedge clk_a);
      #1;
      rst_n = 1'b1;
      // idle handshake levels after reset
      @(negedge clk_a);
      check_value("arready", 32'd1, word_t'(arready));
      check_value("awready", 32'd0, word_t'(awready));
      check_value("wready", 32'd0, word_t'(wready));
      check_value("bvalid", 32'd0, word_t'(bvalid));
      check_value("rvalid", 32'd0, word_t'(rvalid));

      // random full words at random addresses
      for (int i = 0; i < 32; i++) begin
         rnd = lcg_step(rng_state);
         idx_list[i] = int'(rnd[31:24]);
         data = lcg_step(rng_state);
         expect_write(mem_byte_addr(idx_list[i]), data, 4'hf, RESP_OKAY);
         shadow[idx_list[i]] = data;
      end
      for (int i = 0; i < 32; i++) begin
         expect_read(mem_byte_addr(idx_list[i]), shadow[idx_list[i]], RESP_OKAY);
      end

      // partial strobes over known words
      for (int i = 0; i < 8; i++) begin
         idx = 64 + i;
         data = lcg_step(rng_state);
         expect_write(mem_byte_addr(idx), data, 4'hf, RESP_OKAY);
         shadow[idx] = data;
         data = lcg_step(rng_state);
         expect_write(mem_byte_addr(idx), data, strb_pat[i], RESP_OKAY);
         shadow[idx] = merge_bytes(shadow[idx], data, strb_pat[i]);
         expect_read(mem_byte_addr(idx), shadow[idx], RESP_OKAY);
      end

      // register readback and the unmapped offset
      expect_write(reg_byte_addr(REG_BASE), 32'h0000_005a, 4'hf, RESP_OKAY);
      expect_read(reg_byte_addr(REG_BASE), 32'h0000_005a, RESP_OKAY);
      expect_write(reg_byte_addr(REG_LEN), 32'h0000_0137, 4'hf, RESP_OKAY);
      expect_read(reg_byte_addr(REG_LEN), 32'h0000_0137, RESP_OKAY);
      expect_write(reg_byte_addr(REG_FILL), 32'hdead_beef, 4'hf, RESP_OKAY);
      expect_read(reg_byte_addr(REG_FILL), 32'hdead_beef, RESP_OKAY);
      expect_read(12'h418, 32'h0, RESP_SLVERR);
      expect_write(12'h418, 32'h1234_5678, 4'hf, RESP_SLVERR);

      // fill wrapping past word 255
      fill_val = lcg_step(rng_state);
      expect_write(reg_byte_addr(REG_BASE), 32'd250, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_LEN), 32'd12, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_FILL), fill_val, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_CTRL), 32'h3, 4'hf, RESP_OKAY);
      wait_job_done();
      for (int i = 0; i < 12; i++) begin
         idx = (250 + i) % 256;
         shadow[idx] = fill_val + word_t'(i);
         expect_read(mem_byte_addr(idx), shadow[idx], RESP_OKAY);
      end
      // neighbours of the range
      expect_read(mem_byte_addr(249), shadow[249], RESP_OKAY);
      expect_read(mem_byte_addr(6), shadow[6], RESP_OKAY);

      // sum over 40 random words and then over len 0
      for (int i = 0; i < 40; i++) begin
         data = lcg_step(rng_state);
         expect_write(mem_byte_addr(120 + i), data, 4'hf, RESP_OKAY);
         shadow[120 + i] = data;
      end
      expect_write(reg_byte_addr(REG_BASE), 32'd120, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_LEN), 32'd40, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_CTRL), 32'h1, 4'hf, RESP_OKAY);
      wait_job_done();
      sum = '0;
      for (int i = 0; i < 40; i++) begin
         sum = sum + shadow[120 + i];
      end
      expect_read(reg_byte_addr(REG_RESULT), sum, RESP_OKAY);
      expect_write(reg_byte_addr(REG_LEN), 32'd0, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_CTRL), 32'h1, 4'hf, RESP_OKAY);
      wait_job_done();
      expect_read(reg_byte_addr(REG_RESULT), 32'h0, RESP_OKAY);

      // stalled rready and bready
      read_txn(mem_byte_addr(idx_list[0]), 6, data, resp, held);
      check_true(held, "read response changed or arready rose while rready was low");
      check_value("rresp", word_t'(RESP_OKAY), word_t'(resp));
      check_value("rdata", shadow[idx_list[0]], data);
      data = lcg_step(rng_state);
      write_txn(mem_byte_addr(200), data, 4'hf, 6, resp, held);
      check_true(held, "write response changed while bready was low");
      check_value("bresp", word_t'(RESP_OKAY), word_t'(resp));
      shadow[200] = data;
      // long sum with a fill start issued while it runs
      expect_write(reg_byte_addr(REG_BASE), 32'd0, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_LEN), 32'd200, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_CTRL), 32'h1, 4'hf, RESP_OKAY);
      expect_write(reg_byte_addr(REG_CTRL), 32'h3, 4'hf, RESP_OKAY);
      wait_job_done();
      sum = '0;
      for (int i = 0; i < 200; i++) begin
         sum = sum + shadow[i];
      end
      expect_read(reg_byte_addr(REG_RESULT), sum, RESP_OKAY);
      // mode bit still sum
      expect_read(reg_byte_addr(REG_CTRL), 32'h0, RESP_OKAY);

      $display("PASS: all tests");
      $finish;
   end

endmodule

/* csum_scratchpad.f */
+incdir+tb
rtl/scratch_pkg.sv
rtl/scratch_tdpram.sv
rtl/scratch_axil_slave.sv
rtl/scratch_regs.sv
rtl/scratch_block_engine.sv
rtl/csum_scratchpad_top.sv
tb/tb_csum_scratchpad.sv

/* run_sim.sh */
#!/bin/sh
# build and run the csum_scratchpad testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f csum_scratchpad.f \
   --top-module tb_csum_scratchpad \
   -Mdir obj_dir -o sim_csum_scratchpad
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/sim_csum_scratchpad)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the run counts as passed only if the pass line is in the output
if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
   exit 0
else
   echo "pass line not found in simulation output"
   exit 1
fi
